//--- Bender.yml
package:
  name: audio_mix

sources:
  - files:
      - src/audio_pkg.sv
      - src/host_cmd_pkg.sv
      - src/audio_channel_prep.sv
      - src/audio_cmd_regs.sv
      - src/stereo_mix.sv
      - src/audio_mix_top.sv
  - target: test
    files:
      - verif/audio_mix_properties.sv
      - verif/audio_mix_tb.sv

//--- filelist.f
src/audio_pkg.sv
src/host_cmd_pkg.sv
src/audio_channel_prep.sv
src/audio_cmd_regs.sv
src/stereo_mix.sv
src/audio_mix_top.sv
verif/audio_mix_properties.sv
verif/audio_mix_tb.sv

//--- src/audio_channel_prep.sv
/* Channel front end: core sample deglitch, sign conversion
   and the sum with the host sample */

`timescale 1ns/1ps

module audio_channel_prep #(
	parameter int STABLE_CYCLES = 2
) (
	input  logic               clk,
	input  logic               resetd,
	input  audio_pkg::sample_t i_core,
	input  audio_pkg::sample_t i_linux,
	input  logic               i_is_signed,
	output audio_pkg::sum_t    o_sum
);

	// Last core samples, newest in entry 0
	audio_pkg::sample_t [STABLE_CYCLES-1:0] hist;
	logic                                   hist_agree;

	audio_pkg::sample_t accepted;
	audio_pkg::sum_t    ext_q;

	////////////////////
	// Deglitch
	////////////////////

	always_comb begin
		hist_agree = 1'b1;
		for (int i = 1; i < STABLE_CYCLES; i++) begin
			if (hist[i] != hist[0]) begin
				hist_agree = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			hist     <= '0;
			accepted <= '0;
		end else begin
			hist[0] <= i_core;
			for (int i = 1; i < STABLE_CYCLES; i++) begin
				hist[i] <= hist[i-1];
			end
			// Take a new value only once it has held steady
			if (hist_agree) begin
				accepted <= hist[0];
			end
		end
	end

	////////////////////
	// Convert and sum
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			ext_q <= '0;
			o_sum <= '0;
		end else begin
			// Unsigned cores are halved so they fit the signed range
			ext_q <= i_is_signed ? {accepted[15], accepted} : {2'b00, accepted[15:1]};
			o_sum <= ext_q + {i_linux[15], i_linux};
		end
	end

endmodule

//--- src/audio_cmd_regs.sv
/* Host command decoder with the attenuation register
   written by the volume command */

`timescale 1ns/1ps

module audio_cmd_regs (
	input  logic                     clk,
	input  logic                     resetd,
	input  logic                     i_io_uio,
	input  logic                     i_io_strobe,
	input  host_cmd_pkg::host_word_t i_io_din,
	output audio_pkg::att_t          o_att
);

	logic strobe_q;
	logic strobe_rise;

	host_cmd_pkg::cmd_state_t state;
	host_cmd_pkg::host_cmd_t  cmd;

	////////////////////
	// Strobe edge
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= i_io_strobe;
		end
	end

	assign strobe_rise = i_io_strobe & ~strobe_q;

	////////////////////
	// Command FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			state <= host_cmd_pkg::CMD_WAIT;
			cmd   <= '0;
			o_att <= '0;
		end else if (!i_io_uio) begin
			// Deselect ends the current command
			state <= host_cmd_pkg::CMD_WAIT;
		end else if (strobe_rise) begin
			case (state)
				host_cmd_pkg::CMD_WAIT: begin
					cmd   <= i_io_din[7:0];
					state <= host_cmd_pkg::CMD_DATA;
				end
				host_cmd_pkg::CMD_DATA: begin
					// Data for other commands is dropped
					if (cmd == host_cmd_pkg::CMD_VOLUME) begin
						o_att <= i_io_din[$bits(audio_pkg::att_t)-1:0];
					end
				end
				default: begin
					state <= host_cmd_pkg::CMD_WAIT;
				end
			endcase
		end
	end

endmodule

//--- src/audio_mix_top.sv
/* Mixer top level: two channel front ends, host command
   decoder and stereo mixer */

`timescale 1ns/1ps

module audio_mix_top #(
	parameter int STABLE_CYCLES = 2
) (
	input  logic                     clk,
	input  logic                     resetd,
	input  audio_pkg::stereo_t       i_core,
	input  audio_pkg::stereo_t       i_linux,
	input  logic                     i_is_signed,
	input  audio_pkg::mix_t          i_mix,
	input  logic                     i_io_uio,
	input  logic                     i_io_strobe,
	input  host_cmd_pkg::host_word_t i_io_din,
	output audio_pkg::stereo_t       o_audio
);

	audio_pkg::stereo_sum_t sum;
	audio_pkg::att_t        att;

	////////////////////
	// Channel inputs
	////////////////////

	audio_channel_prep #(
		.STABLE_CYCLES(STABLE_CYCLES)
	) u_prep_left (
		.clk        (clk),
		.resetd     (resetd),
		.i_core     (i_core.left),
		.i_linux    (i_linux.left),
		.i_is_signed(i_is_signed),
		.o_sum      (sum.left)
	);

	audio_channel_prep #(
		.STABLE_CYCLES(STABLE_CYCLES)
	) u_prep_right (
		.clk        (clk),
		.resetd     (resetd),
		.i_core     (i_core.right),
		.i_linux    (i_linux.right),
		.i_is_signed(i_is_signed),
		.o_sum      (sum.right)
	);

	////////////////////
	// Volume and mix
	////////////////////

	audio_cmd_regs u_cmd_regs (
		.clk        (clk),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_strobe(i_io_strobe),
		.i_io_din   (i_io_din),
		.o_att      (att)
	);

	stereo_mix u_stereo_mix (
		.clk    (clk),
		.resetd (resetd),
		.i_sum  (sum),
		.i_mix  (i_mix),
		.i_att  (att),
		.o_audio(o_audio)
	);

endmodule

//--- src/audio_pkg.sv
/* Audio path types: sample and sum widths, stereo pair structs,
   attenuation word and stereo-separation select with its constants */

package audio_pkg;

	////////////////////
	// Sample widths
	////////////////////

	// One audio sample, two's complement unless noted
	typedef logic [15:0] sample_t;

	// Channel sum with one guard bit
	typedef logic [16:0] sum_t;

	////////////////////
	// Stereo pairs
	////////////////////

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef struct packed {
		sum_t left;
		sum_t right;
	} stereo_sum_t;

	////////////////////
	// Output controls
	////////////////////

	// Bit 4 mutes, bits 3:0 are the right shift
	typedef logic [4:0] att_t;

	// Stereo separation, none to full mono
	typedef logic [1:0] mix_t;

	localparam mix_t MIX_NONE   = 2'd0;
	localparam mix_t MIX_LIGHT  = 2'd1;
	localparam mix_t MIX_MEDIUM = 2'd2;
	localparam mix_t MIX_MONO   = 2'd3;

endpackage

//--- src/host_cmd_pkg.sv
/* Host command bus: word and command code types, command codes
   and the decoder state enum */

package host_cmd_pkg;

	////////////////////
	// Bus words
	////////////////////

	// One word on the strobed host bus
	typedef logic [15:0] host_word_t;

	// Command code, taken from the low byte of the first word
	typedef logic [7:0] host_cmd_t;

	////////////////////
	// Command codes
	////////////////////

	// Data words set the output attenuation
	localparam host_cmd_t CMD_VOLUME = 8'h26;

	////////////////////
	// Decoder states
	////////////////////

	// Waiting for a command word, or taking data words after one
	typedef enum logic {
		CMD_WAIT = 1'b0,
		CMD_DATA = 1'b1
	} cmd_state_t;

endpackage

//--- src/stereo_mix.sv
/* Stereo cross-mix of the two channel sums, then
   attenuation and clamping to 16 bits signed */

`timescale 1ns/1ps

module stereo_mix (
	input  logic                   clk,
	input  logic                   resetd,
	input  audio_pkg::stereo_sum_t i_sum,
	input  audio_pkg::mix_t        i_mix,
	input  audio_pkg::att_t        i_att,
	output audio_pkg::stereo_t     o_audio
);

	// Halved sums, read by the opposite channel
	audio_pkg::stereo_t     pre;
	audio_pkg::stereo_sum_t mixed;
	audio_pkg::att_t        att_q;
	audio_pkg::stereo_sum_t scaled;

	////////////////////
	// Channel helpers
	////////////////////

	function automatic audio_pkg::sum_t mix_value(
		input audio_pkg::sum_t    s,
		input audio_pkg::sample_t pre_other,
		input audio_pkg::mix_t    mix
	);
		logic signed [16:0] ss;
		logic signed [16:0] po;
		ss = $signed(s);
		po = $signed({pre_other[15], pre_other});
		case (mix)
			audio_pkg::MIX_NONE:   mix_value = ss;
			audio_pkg::MIX_LIGHT:  mix_value = ss - (ss >>> 3) + (po >>> 2);
			audio_pkg::MIX_MEDIUM: mix_value = ss - (ss >>> 2) + (po >>> 1);
			audio_pkg::MIX_MONO:   mix_value = (ss >>> 1) + po;
		endcase
	endfunction

	function automatic audio_pkg::sum_t attenuate(
		input audio_pkg::sum_t m,
		input audio_pkg::att_t att
	);
		logic signed [16:0] ms;
		ms = $signed(m);
		if (att[4]) begin
			attenuate = '0;
		end else begin
			attenuate = ms >>> att[3:0];
		end
	endfunction

	// Guard bit disagrees with the sign on overflow
	function automatic audio_pkg::sample_t clamp(input audio_pkg::sum_t v);
		if (v[16] != v[15]) begin
			clamp = v[16] ? 16'h8000 : 16'h7fff;
		end else begin
			clamp = v[15:0];
		end
	endfunction

	////////////////////
	// Pipeline
	////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			pre     <= '0;
			mixed   <= '0;
			att_q   <= '0;
			scaled  <= '0;
			o_audio <= '0;
		end else begin
			// Stage 1
			pre.left    <= i_sum.left[16:1];
			pre.right   <= i_sum.right[16:1];
			mixed.left  <= mix_value(i_sum.left, pre.right, i_mix);
			mixed.right <= mix_value(i_sum.right, pre.left, i_mix);
			att_q       <= i_att;

			// Stage 2
			scaled.left  <= attenuate(mixed.left, att_q);
			scaled.right <= attenuate(mixed.right, att_q);

			// Stage 3
			o_audio.left  <= clamp(scaled.left);
			o_audio.right <= clamp(scaled.right);
		end
	end

endmodule

//--- verif/audio_mix_properties.sv
/* Concurrent assertions on the stereo mixer: reset,
   mute and clamping */

`timescale 1ns/1ps

module audio_mix_properties (
	input logic                   clk,
	input logic                   resetd,
	input audio_pkg::att_t        i_att,
	input audio_pkg::stereo_sum_t i_scaled,
	input audio_pkg::stereo_t     i_audio
);

	int fail_count = 0;

	// Output registers clear with reset
	reset_clears: assert property (@(posedge clk) resetd |=> i_audio == '0)
		else begin
			fail_count++;
			$error("output not zero in the cycle after reset");
		end

	// Mute passes through three register stages
	mute_zero: assert property (@(posedge clk) disable iff (resetd)
		i_att[4] |-> ##3 i_audio == '0)
		else begin
			fail_count++;
			$error("output not zero three cycles after mute");
		end

	////////////////////
	// Saturation
	////////////////////

	clamp_left: assert property (@(posedge clk) disable iff (resetd)
		(i_scaled.left[16] != i_scaled.left[15]) |=>
		i_audio.left == ($past(i_scaled.left[16]) ? 16'h8000 : 16'h7fff))
		else begin
			fail_count++;
			$error("left overflow not saturated with matching sign");
		end

	clamp_right: assert property (@(posedge clk) disable iff (resetd)
		(i_scaled.right[16] != i_scaled.right[15]) |=>
		i_audio.right == ($past(i_scaled.right[16]) ? 16'h8000 : 16'h7fff))
		else begin
			fail_count++;
			$error("right overflow not saturated with matching sign");
		end

endmodule

//--- verif/audio_mix_tb.sv
/* Testbench for the audio mixer: clock, reset, reference model
   of the mixer rules and directed tests */

`timescale 1ns/1ps

module audio_mix_tb;

	// About 1000 cycles of tests, so this limit leaves a wide margin
	localparam int MAX_CYCLES = 3000;
	localparam int SETTLE     = 16;

	logic                     clk;
	logic                     resetd;
	audio_pkg::stereo_t       core;
	audio_pkg::stereo_t       linux;
	logic                     is_signed;
	audio_pkg::mix_t          mix;
	logic                     io_uio;
	logic                     io_strobe;
	host_cmd_pkg::host_word_t io_din;
	audio_pkg::stereo_t       audio;

	// Attenuation the DUT should hold after the host writes
	audio_pkg::att_t att_model;
	integer          seed;
	int              cycle_count;

	audio_mix_top #(
		.STABLE_CYCLES(2)
	) DUT (
		.clk        (clk),
		.resetd     (resetd),
		.i_core     (core),
		.i_linux    (linux),
		.i_is_signed(is_signed),
		.i_mix      (mix),
		.i_io_uio   (io_uio),
		.i_io_strobe(io_strobe),
		.i_io_din   (io_din),
		.o_audio    (audio)
	);

	bind stereo_mix audio_mix_properties u_props (
		.clk     (clk),
		.resetd  (resetd),
		.i_att   (i_att),
		.i_scaled(scaled),
		.i_audio (o_audio)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run went past %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	////////////////////
	// Reference model
	////////////////////

	// Keep the low 17 bits as a signed value
	function automatic int wrap17(input int v);
		int r;
		r = v & 32'h0001_ffff;
		if (r > 65535) begin
			r = r - 131072;
		end
		return r;
	endfunction

	function automatic int channel_sum(
		input audio_pkg::sample_t c,
		input audio_pkg::sample_t h,
		input logic               sgn
	);
		int cv;
		cv = sgn ? int'($signed(c)) : (int'(c) >> 1);
		return wrap17(cv + int'($signed(h)));
	endfunction

	function automatic int cross_mix(input int s, input int other, input audio_pkg::mix_t m);
		int p;
		int r;
		p = other >>> 1;
		case (m)
			audio_pkg::MIX_LIGHT:  r = s - (s >>> 3) + (p >>> 2);
			audio_pkg::MIX_MEDIUM: r = s - (s >>> 2) + (p >>> 1);
			audio_pkg::MIX_MONO:   r = (s >>> 1) + p;
			default:               r = s;
		endcase
		return wrap17(r);
	endfunction

	function automatic audio_pkg::sample_t scale_and_clamp(input int m, input audio_pkg::att_t a);
		int v;
		if (a[4]) begin
			return 16'h0000;
		end
		v = m >>> a[3:0];
		if (v > 32767) begin
			return 16'h7fff;
		end else if (v < -32768) begin
			return 16'h8000;
		end
		return v[15:0];
	endfunction

	// Settled output for the inputs being driven now
	function automatic audio_pkg::stereo_t expected_audio();
		audio_pkg::stereo_t e;
		int sl;
		int sr;
		sl = channel_sum(core.left, linux.left, is_signed);
		sr = channel_sum(core.right, linux.right, is_signed);
		e.left  = scale_and_clamp(cross_mix(sl, sr, mix), att_model);
		e.right = scale_and_clamp(cross_mix(sr, sl, mix), att_model);
		return e;
	endfunction

	function automatic audio_pkg::stereo_t random_pair();
		audio_pkg::stereo_t r;
		r.left  = $random(seed);
		r.right = $random(seed);
		return r;
	endfunction

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	// Lands 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check_audio(input string name, input audio_pkg::stereo_t exp);
		assert (audio === exp) else begin
			$display("mismatch %s: expected %h actual %h", name, exp, audio);
			abort_run();
		end
	endtask

	task automatic settle_and_check(input string name);
		wait_cycles(SETTLE);
		check_audio(name, expected_audio());
	endtask

	// One host word, strobe high for a cycle then low for a cycle
	task automatic host_write(input host_cmd_pkg::host_word_t w);
		io_din    = w;
		io_strobe = 1'b1;
		wait_cycles(1);
		io_strobe = 1'b0;
		wait_cycles(1);
	endtask

	task automatic reselect_host();
		io_uio = 1'b0;
		wait_cycles(2);
		io_uio = 1'b1;
		wait_cycles(1);
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset_passthrough();
		check_audio("reset", '0);
		mix = audio_pkg::MIX_NONE;
		for (int i = 0; i < 12; i++) begin
			is_signed = (i < 6);
			core      = random_pair();
			linux     = random_pair();
			settle_and_check("passthrough");
		end
	endtask

	task automatic test_clamping();
		logic [12:0] r;
		mix       = audio_pkg::MIX_NONE;
		is_signed = 1'b1;
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			// Left large positive, right large negative, then swapped
			core.left   = (i % 2) ? {3'b100, r} : {3'b011, r};
			linux.left  = (i % 2) ? {3'b100, ~r} : {3'b011, ~r};
			core.right  = ~core.left;
			linux.right = ~linux.left;
			settle_and_check("clamping");
		end
	endtask

	task automatic test_cross_mix();
		audio_pkg::mix_t modes [3];
		modes[0] = audio_pkg::MIX_LIGHT;
		modes[1] = audio_pkg::MIX_MEDIUM;
		modes[2] = audio_pkg::MIX_MONO;
		foreach (modes[m]) begin
			mix = modes[m];
			for (int i = 0; i < 6; i++) begin
				is_signed = i[0];
				core      = random_pair();
				linux     = random_pair();
				settle_and_check("cross_mix");
			end
		end
	endtask

	task automatic test_volume_command();
		logic [10:0] upper;
		mix       = audio_pkg::MIX_NONE;
		is_signed = 1'b1;
		core      = random_pair();
		linux     = random_pair();
		io_uio    = 1'b1;
		wait_cycles(1);
		upper = $random(seed);
		host_write({upper[7:0], host_cmd_pkg::CMD_VOLUME});
		for (int sh = 0; sh < 16; sh++) begin
			upper = $random(seed);
			host_write({upper, 1'b0, sh[3:0]});
			att_model = {1'b0, sh[3:0]};
			settle_and_check("volume_shift");
		end
		// Mute with random shift bits
		upper = $random(seed);
		host_write({upper, 1'b1, upper[3:0]});
		att_model = {1'b1, upper[3:0]};
		settle_and_check("volume_mute");
		host_write(16'h0003);
		att_model = 5'h03;
		settle_and_check("volume_set");
		// After deselect the next word is a command again, not volume data
		reselect_host();
		host_write(16'h0031);
		settle_and_check("reselect");
		// Data for another command is dropped
		host_write(16'h0010);
		settle_and_check("other_command");
		io_uio = 1'b0;
	endtask

	task automatic test_deglitch();
		audio_pkg::stereo_t steady;
		mix = audio_pkg::MIX_NONE;
		for (int i = 0; i < 2; i++) begin
			is_signed = i[0];
			steady    = random_pair();
			core      = steady;
			linux     = random_pair();
			settle_and_check("deglitch_settle");
			core = ~steady;
			wait_cycles(1);
			core = steady;
			repeat (SETTLE) begin
				check_audio("deglitch", expected_audio());
				wait_cycles(1);
			end
		end
	endtask

	initial begin
		seed        = 32'ha921_98b3;
		cycle_count = 0;
		clk         = 1'b0;
		resetd      = 1'b1;
		core        = '0;
		linux       = '0;
		is_signed   = 1'b1;
		mix         = audio_pkg::MIX_NONE;
		io_uio      = 1'b0;
		io_strobe   = 1'b0;
		io_din      = '0;
		att_model   = '0;
		wait_cycles(4);
		resetd = 1'b0;

		test_reset_passthrough();
		test_clamping();
		test_cross_mix();
		test_volume_command();
		test_deglitch();

		if (DUT.u_stereo_mix.u_props.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("stereo mixer assertions failed %0d times",
				DUT.u_stereo_mix.u_props.fail_count);
			abort_run();
		end
	end

endmodule
